//--- hdl/masked_bfu_cfg.svh
/*
 * masked butterfly configuration
 * share width, modulus, block size and datapath latency
 */

`ifndef MASKED_BFU_CFG_SVH
`define MASKED_BFU_CFG_SVH

// share width, arithmetic shares live mod 2^24
`define MBFU_WIDTH 24

// ml-dsa prime, below 2^23 so bit 23 is a clean sign
`define MBFU_Q 8380417

// largest block in coefficients
`define MBFU_MAX_COUNT 256

// add reg + a2b stages + b2a reg + correction reg
`define MBFU_LATENCY (`MBFU_WIDTH + 3)

`endif

//--- hdl/masked_bfu_pkg.sv
/*
 * masked butterfly shared types
 * one storage word for a pair of shares, readable as arithmetic
 * shares (sum mod 2^w) or as boolean shares (xor), plus the
 * block control states
 */

`include "masked_bfu_cfg.svh"

package masked_bfu_pkg;

    // ====================
    // share pair
    // ====================

    // same 2*w bits seen two ways
    // a2b conversion overwrites arith bits with bool bits in place
    typedef union packed {
        struct packed {
            logic [`MBFU_WIDTH-1:0] s1;
            logic [`MBFU_WIDTH-1:0] s0;
        } arith;
        struct packed {
            logic [`MBFU_WIDTH-1:0] b1;
            logic [`MBFU_WIDTH-1:0] b0;
        } bool;
    } share_pair_u;

    // ====================
    // block control
    // ====================

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        DRAIN = 2'd2,
        DONE  = 2'd3
    } bfu_state_e;

endpackage

//--- hdl/masked_a2b_conv.sv
/*
 * masked arithmetic to boolean conversion
 * ripple carry over the two shares, one bit per pipeline stage,
 * carry kept as two boolean shares with a fresh random bit per stage
 */

`timescale 1ns/1ps

`include "masked_bfu_cfg.svh"

module masked_a2b_conv (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  masked_bfu_pkg::share_pair_u x_arith,
    input  logic [`MBFU_WIDTH-1:0]      rnd,
    output masked_bfu_pkg::share_pair_u x_bool
);
    import masked_bfu_pkg::*;

    localparam int W = `MBFU_WIDTH;

    // stage i holds bits [i:0] in bool form, the rest still arith
    share_pair_u  stage_d [W];
    share_pair_u  stage_q [W];
    // carry shares out of stages 0..w-2
    logic [W-2:0] c0_d;
    logic [W-2:0] c1_d;
    logic [W-2:0] c0_q;
    logic [W-2:0] c1_q;

    for (genvar i = 0; i < W; i++) begin : g_bit
        share_pair_u cur;
        share_pair_u nxt;
        logic        k0;
        logic        k1;
        logic        m;

        // stage input, first stage has no carry in
        if (i == 0) begin : g_first
            assign cur = x_arith;
            assign k0  = 1'b0;
            assign k1  = 1'b0;
        end else begin : g_next
            assign cur = stage_q[i-1];
            assign k0  = c0_q[i-1];
            assign k1  = c1_q[i-1];
        end

        // last stage has no carry out, its random bit remasks the msb
        if (i == W - 1) begin : g_top_mask
            assign m = rnd[i];
        end else begin : g_no_mask
            assign m = 1'b0;
        end

        // sum bit = s0 ^ s1 ^ carry, share 0 keeps s0, share 1 keeps s1
        always_comb begin
            nxt = cur;
            nxt.bool.b0[i] = cur.arith.s0[i] ^ k0 ^ m;
            nxt.bool.b1[i] = cur.arith.s1[i] ^ k1 ^ m;
        end

        assign stage_d[i] = nxt;

        // carry out = maj(a, b, c) = ((a^c) & (b^c)) ^ c
        // and of the two shared operands done dom style with rnd[i]
        if (i < W - 1) begin : g_carry
            logic x0;
            logic x1;
            logic y0;
            logic y1;
            logic z0;
            logic z1;

            assign x0 = cur.arith.s0[i] ^ k0;
            assign x1 = k1;
            assign y0 = k0;
            assign y1 = cur.arith.s1[i] ^ k1;
            // cross terms masked by the same fresh bit
            assign z0 = (x0 & y0) ^ ((x0 & y1) ^ rnd[i]);
            assign z1 = (x1 & y1) ^ ((x1 & y0) ^ rnd[i]);
            assign c0_d[i] = z0 ^ k0;
            assign c1_d[i] = z1 ^ k1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < W; i++) begin
                stage_q[i] <= '0;
            end
            c0_q <= '0;
            c1_q <= '0;
        end else if (zeroize) begin
            for (int i = 0; i < W; i++) begin
                stage_q[i] <= '0;
            end
            c0_q <= '0;
            c1_q <= '0;
        end else begin
            stage_q <= stage_d;
            c0_q    <= c0_d;
            c1_q    <= c1_d;
        end
    end

    // all bits converted after the last stage
    assign x_bool = stage_q[W-1];

endmodule

//--- hdl/masked_b2a_bit.sv
/*
 * one bit boolean to arithmetic share conversion
 * goubin affine trick on a zero-extended bit, then an additive remask,
 * result registered
 */

`timescale 1ns/1ps

`include "masked_bfu_cfg.svh"

module masked_b2a_bit (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  logic                        b0,
    input  logic                        b1,
    input  logic [`MBFU_WIDTH-1:0]      rnd,
    output masked_bfu_pkg::share_pair_u a
);

    localparam int W = `MBFU_WIDTH;

    logic [W-1:0] xm;
    logic [W-1:0] mk;
    logic [W-1:0] g_a;
    logic [W-1:0] g_t;
    logic [W-1:0] a_x;

    // masked value and mask, both one bit wide
    assign xm = {{(W-1){1'b0}}, b0};
    assign mk = {{(W-1){1'b0}}, b1};

    // f(g) = (xm ^ g) - g is affine in g
    assign g_a = ((xm ^ rnd) - rnd) ^ xm;
    assign g_t = (xm ^ (rnd ^ mk)) - (rnd ^ mk);
    // a_x + mk == b0 ^ b1 mod 2^w
    assign a_x = g_a ^ g_t;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a <= '0;
        end else if (zeroize) begin
            a <= '0;
        end else begin
            // spread both shares over the full word
            a.arith.s0 <= a_x + rnd;
            a.arith.s1 <= mk - rnd;
        end
    end

endmodule

//--- hdl/masked_bfu_add_sub.sv
/*
 * masked modular add/sub butterfly
 * t = u + v - q or u - v share by share, sign of t recovered through
 * a2b and a one bit b2a, then q added back when t is negative
 * result stays in two arithmetic shares
 */

`timescale 1ns/1ps

`include "masked_bfu_cfg.svh"

module masked_bfu_add_sub (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize,
    input  logic                        in_valid,
    input  logic                        mode_sub,
    input  masked_bfu_pkg::share_pair_u u,
    input  masked_bfu_pkg::share_pair_u v,
    input  logic [`MBFU_WIDTH-1:0]      rnd_a2b,
    input  logic [`MBFU_WIDTH-1:0]      rnd_b2a,
    output masked_bfu_pkg::share_pair_u res,
    output logic                        res_valid
);
    import masked_bfu_pkg::*;

    localparam int W   = `MBFU_WIDTH;
    localparam int LAT = `MBFU_LATENCY;
    // t waits through a2b and b2a
    localparam int DLY = LAT - 2;
    localparam logic [W-1:0] Q = W'(`MBFU_Q);

    share_pair_u    t_d;
    share_pair_u    t_q;
    share_pair_u    t_dly [DLY];
    share_pair_u    t_bool;
    share_pair_u    sgn_arith;
    share_pair_u    res_d;
    logic [LAT-1:0] vld_q;

    // ====================
    // share-wise add/sub
    // ====================

    // q folded into share 0 only
    always_comb begin
        if (mode_sub) begin
            t_d.arith.s0 = u.arith.s0 - v.arith.s0;
            t_d.arith.s1 = u.arith.s1 - v.arith.s1;
        end else begin
            t_d.arith.s0 = u.arith.s0 + v.arith.s0 - Q;
            t_d.arith.s1 = u.arith.s1 + v.arith.s1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            t_q   <= '0;
            vld_q <= '0;
            for (int i = 0; i < DLY; i++) begin
                t_dly[i] <= '0;
            end
        end else if (zeroize) begin
            t_q   <= '0;
            vld_q <= '0;
            for (int i = 0; i < DLY; i++) begin
                t_dly[i] <= '0;
            end
        end else begin
            t_q      <= t_d;
            // valid walks alongside the data
            vld_q    <= {vld_q[LAT-2:0], in_valid};
            t_dly[0] <= t_q;
            for (int i = 1; i < DLY; i++) begin
                t_dly[i] <= t_dly[i-1];
            end
        end
    end

    // ====================
    // sign extract
    // ====================

    masked_a2b_conv u_a2b (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .x_arith (t_q),
        .rnd     (rnd_a2b),
        .x_bool  (t_bool)
    );

    // only bit 23 of each bool share goes on
    masked_b2a_bit u_b2a (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .b0      (t_bool.bool.b0[W-1]),
        .b1      (t_bool.bool.b1[W-1]),
        .rnd     (rnd_b2a),
        .a       (sgn_arith)
    );

    // ====================
    // q correction
    // ====================

    // q * (a0 + a1) == q * sign, added per share
    assign res_d.arith.s0 = t_dly[DLY-1].arith.s0 + sgn_arith.arith.s0 * Q;
    assign res_d.arith.s1 = t_dly[DLY-1].arith.s1 + sgn_arith.arith.s1 * Q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res <= '0;
        end else if (zeroize) begin
            res <= '0;
        end else begin
            res <= res_d;
        end
    end

    assign res_valid = vld_q[LAT-1];

endmodule

//--- hdl/bfu_ctrl_fsm.sv
/*
 * butterfly block control FSM
 * idle -> run -> drain -> done, gates input strobes and
 * flags the end of a block once the pipeline is empty
 */

`timescale 1ns/1ps

module bfu_ctrl_fsm (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize,
    input  logic start,
    input  logic coef_valid,
    input  logic last_coef,
    input  logic drain_end,
    output logic accept,
    output logic load,
    output logic drain_en,
    output logic busy,
    output logic done
);
    import masked_bfu_pkg::*;

    bfu_state_e state_q;
    bfu_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_d = RUN;
                end
            end
            // last_coef already qualified by accept
            RUN: begin
                if (last_coef) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                if (drain_end) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
        end else if (zeroize) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // start outside idle falls on the floor
    assign load     = start && (state_q == IDLE);
    assign accept   = coef_valid && (state_q == RUN);
    assign drain_en = (state_q == DRAIN);
    assign busy     = (state_q == RUN) || (state_q == DRAIN);
    assign done     = (state_q == DONE);

endmodule

//--- hdl/bfu_block_counter.sv
/*
 * butterfly block counter
 * counts down accepted coefficients and up through the drain,
 * flags the last accept and the end of the drain
 */

`timescale 1ns/1ps

`include "masked_bfu_cfg.svh"

module bfu_block_counter (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   zeroize,
    input  logic                                   load,
    input  logic                                   accept,
    input  logic                                   drain_en,
    input  logic [$clog2(`MBFU_MAX_COUNT + 1)-1:0] count,
    output logic                                   last_coef,
    output logic                                   drain_end
);

    localparam int CW = $clog2(`MBFU_MAX_COUNT + 1);
    localparam int DW = $clog2(`MBFU_LATENCY);

    // coefficients still to accept
    logic [CW-1:0] remain_q;
    // drain cycles seen so far
    logic [DW-1:0] drain_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            remain_q <= '0;
            drain_q  <= '0;
        end else if (zeroize) begin
            remain_q <= '0;
            drain_q  <= '0;
        end else if (load) begin
            remain_q <= count;
            drain_q  <= '0;
        end else begin
            if (accept) begin
                remain_q <= remain_q - 1'b1;
            end
            if (drain_en) begin
                drain_q <= drain_q + 1'b1;
            end
        end
    end

    assign last_coef = accept && (remain_q == CW'(1));
    // drain spans the full latency so the last result has left
    assign drain_end = drain_en && (drain_q == DW'(`MBFU_LATENCY - 1));

endmodule

//--- hdl/masked_bfu_top.sv
/*
 * masked butterfly add/sub unit, top level
 * block control and counter around the shared datapath
 */

`timescale 1ns/1ps

`include "masked_bfu_cfg.svh"

module masked_bfu_top (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   zeroize,
    input  logic                                   start,
    input  logic                                   mode_sub,
    input  logic [$clog2(`MBFU_MAX_COUNT + 1)-1:0] count,
    input  logic                                   coef_valid,
    input  masked_bfu_pkg::share_pair_u            u,
    input  masked_bfu_pkg::share_pair_u            v,
    input  logic [`MBFU_WIDTH-1:0]                 rnd_a2b,
    input  logic [`MBFU_WIDTH-1:0]                 rnd_b2a,
    output masked_bfu_pkg::share_pair_u            res,
    output logic                                   res_valid,
    output logic                                   busy,
    output logic                                   done
);

    logic accept;
    logic load;
    logic drain_en;
    logic last_coef;
    logic drain_end;
    logic mode_q;

    bfu_ctrl_fsm u_fsm (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .start      (start),
        .coef_valid (coef_valid),
        .last_coef  (last_coef),
        .drain_end  (drain_end),
        .accept     (accept),
        .load       (load),
        .drain_en   (drain_en),
        .busy       (busy),
        .done       (done)
    );

    bfu_block_counter u_cnt (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .load      (load),
        .accept    (accept),
        .drain_en  (drain_en),
        .count     (count),
        .last_coef (last_coef),
        .drain_end (drain_end)
    );

    // mode held for the whole block, taken with the counter load
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode_q <= 1'b0;
        end else if (zeroize) begin
            mode_q <= 1'b0;
        end else if (load) begin
            mode_q <= mode_sub;
        end
    end

    masked_bfu_add_sub u_bfu (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (accept),
        .mode_sub  (mode_q),
        .u         (u),
        .v         (v),
        .rnd_a2b   (rnd_a2b),
        .rnd_b2a   (rnd_b2a),
        .res       (res),
        .res_valid (res_valid)
    );

endmodule

//--- dv/masked_bfu_props.sv
/*
 * masked butterfly checks
 * bound into the top level, rebuilds (u op v) mod q from the plain
 * operand values and watches block control, gating and clearing
 */

`timescale 1ns/1ps

`include "masked_bfu_cfg.svh"

module masked_bfu_props (
    input logic                                   clk,
    input logic                                   reset_n,
    input logic                                   zeroize,
    input logic                                   load,
    input logic                                   accept,
    input logic                                   mode_sub,
    input logic [$clog2(`MBFU_MAX_COUNT + 1)-1:0] count,
    input masked_bfu_pkg::share_pair_u            u,
    input masked_bfu_pkg::share_pair_u            v,
    input masked_bfu_pkg::share_pair_u            res,
    input logic                                   res_valid,
    input logic                                   busy,
    input logic                                   done
);
    import masked_bfu_pkg::*;

    localparam int W   = `MBFU_WIDTH;
    localparam int LAT = `MBFU_LATENCY;
    localparam int CW  = $clog2(`MBFU_MAX_COUNT + 1);

    logic [W-1:0]   exp_now;
    logic [W-1:0]   exp_out;
    logic [W-1:0]   res_sum;
    logic [W-1:0]   exp_line [LAT];
    logic [LAT-1:0] acc_line;
    logic [CW-1:0]  n_q;
    logic [CW-1:0]  res_cnt;
    logic           mode_ref;
    int             fail_cnt = 0;

    // plain values are share sums mod 2^w, operands below q
    function automatic logic [W-1:0] mod_result(input share_pair_u a, input share_pair_u b,
                                                 input logic sub);
        logic [W:0] x;
        logic [W:0] y;
        logic [W:0] r;
        x = {1'b0, a.arith.s0 + a.arith.s1};
        y = {1'b0, b.arith.s0 + b.arith.s1};
        if (sub) begin
            r = (x >= y) ? x - y : x + (W+1)'(`MBFU_Q) - y;
        end else begin
            r = x + y;
            if (r >= (W+1)'(`MBFU_Q)) begin
                r = r - (W+1)'(`MBFU_Q);
            end
        end
        return r[W-1:0];
    endfunction

    assign exp_now = mod_result(u, v, mode_ref);
    assign exp_out = exp_line[LAT-1];
    assign res_sum = res.arith.s0 + res.arith.s1;

    // ====================
    // reference pipeline
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < LAT; i++) begin
                exp_line[i] <= '0;
            end
            acc_line <= '0;
            n_q      <= '0;
            res_cnt  <= '0;
            mode_ref <= 1'b0;
        end else begin
            exp_line[0] <= exp_now;
            for (int i = 1; i < LAT; i++) begin
                exp_line[i] <= exp_line[i-1];
            end
            acc_line <= {acc_line[LAT-2:0], accept};
            // block bookkeeping
            if (zeroize) begin
                n_q     <= '0;
                res_cnt <= '0;
            end else if (load) begin
                n_q      <= count;
                res_cnt  <= '0;
                mode_ref <= mode_sub;
            end else begin
                res_cnt <= res_cnt + CW'(res_valid);
            end
        end
    end

    // ====================
    // assertions
    // ====================

    a_origin: assert property (@(posedge clk) disable iff (!reset_n)
        res_valid |-> acc_line[LAT-1])
        else begin
            fail_cnt = fail_cnt + 1;
            $error("res_valid without an accepted input %0d cycles before", LAT);
        end

    a_result: assert property (@(posedge clk) disable iff (!reset_n)
        res_valid |-> (res_sum == exp_out))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("error t=%0t res: got %h expected %h", $time, $sampled(res_sum),
                   $sampled(exp_out));
        end

    // strobes in idle or drain leave no result outside a block
    a_gate: assert property (@(posedge clk) disable iff (!reset_n)
        res_valid |-> busy)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("res_valid seen while no block was running");
        end

    a_done: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> ($past(res_valid) && !res_valid && !busy && res_cnt == n_q))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("done out of place or wrong number of results in the block");
        end

    a_busy: assert property (@(posedge clk) disable iff (!reset_n)
        ((load || busy) && !zeroize) |=> (busy || done))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("busy dropped between start and done");
        end

    // reset and zeroize clear all outputs on the next edge
    a_clear: assert property (@(posedge clk)
        (!reset_n || zeroize) |=> (!res_valid && !busy && !done && res == '0))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("outputs not cleared after reset or zeroize");
        end

endmodule

//--- dv/masked_bfu_tb.sv
/*
 * masked butterfly testbench
 * random add and sub blocks with gaps, zeroize mid-block and a reset
 * between blocks, results checked by the bound property module
 */

`timescale 1ns/1ps

`include "masked_bfu_cfg.svh"

module masked_bfu_tb;
    import masked_bfu_pkg::*;

    localparam int W          = `MBFU_WIDTH;
    localparam int CW         = $clog2(`MBFU_MAX_COUNT + 1);
    localparam int DONE_LIMIT = 4 * `MBFU_LATENCY;

    logic          clk;
    logic          reset_n;
    logic          zeroize;
    logic          start;
    logic          mode_sub;
    logic [CW-1:0] count;
    logic          coef_valid;
    share_pair_u   u;
    share_pair_u   v;
    logic [W-1:0]  rnd_a2b;
    logic [W-1:0]  rnd_b2a;
    share_pair_u   res;
    logic          res_valid;
    logic          busy;
    logic          done;

    integer seed;
    int     timeout_cnt;
    int     assert_cnt;

    masked_bfu_top u_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .start      (start),
        .mode_sub   (mode_sub),
        .count      (count),
        .coef_valid (coef_valid),
        .u          (u),
        .v          (v),
        .rnd_a2b    (rnd_a2b),
        .rnd_b2a    (rnd_b2a),
        .res        (res),
        .res_valid  (res_valid),
        .busy       (busy),
        .done       (done)
    );

    bind masked_bfu_top masked_bfu_props u_props (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .load       (load),
        .accept     (accept),
        .mode_sub   (mode_sub),
        .count      (count),
        .u          (u),
        .v          (v),
        .res        (res),
        .res_valid  (res_valid),
        .busy       (busy),
        .done       (done)
    );

    always #5 clk = ~clk;

    // ====================
    // stimulus helpers
    // ====================

    // one rising edge, randomness refreshed every cycle
    task automatic tick();
        @(posedge clk);
        rnd_a2b <= W'($random(seed));
        rnd_b2a <= W'($random(seed));
    endtask

    function automatic share_pair_u split_shares(input logic [W-1:0] x, input logic [W-1:0] r);
        share_pair_u p;
        p.arith.s0 = r;
        p.arith.s1 = x - r;
        return p;
    endfunction

    // order 0 any, 1 forces u < v, 2 forces u >= v
    task automatic drive_operands(input int order);
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] t;
        a = W'($unsigned($random(seed)) % `MBFU_Q);
        b = W'($unsigned($random(seed)) % `MBFU_Q);
        if ((order == 1 && a >= b) || (order == 2 && a < b)) begin
            t = a;
            a = b;
            b = t;
        end
        u <= split_shares(a, W'($random(seed)));
        v <= split_shares(b, W'($random(seed)));
    endtask

    task automatic hold_reset();
        reset_n <= 1'b0;
        for (int i = 0; i < 5; i++) begin
            tick();
        end
        reset_n <= 1'b1;
    endtask

    // n coefficients with gaps, cut > 0 zeroizes after cut accepts
    task automatic run_block(input int n, input logic sub, input int cut);
        int   sent;
        int   target;
        logic vld;
        sent   = 0;
        target = (cut > 0) ? cut : n;
        tick();
        // strobe already up while idle
        start      <= 1'b1;
        mode_sub   <= sub;
        count      <= CW'(n);
        coef_valid <= 1'b1;
        drive_operands(0);
        tick();
        start <= 1'b0;
        for (int i = 0; i < 8 * target + 16 && sent < target; i++) begin
            vld = ($random(seed) & 3) != 0;
            coef_valid <= vld;
            drive_operands(sent % 3);
            if (vld) begin
                sent++;
            end
            tick();
        end
        coef_valid <= 1'b0;
        if (sent < target) begin
            timeout_cnt++;
            $display("timeout: only %0d of %0d coefficients were sent", sent, target);
        end
        if (cut > 0) begin
            // pipeline still holds results here
            zeroize <= 1'b1;
            tick();
            zeroize <= 1'b0;
            for (int i = 0; i < 3; i++) begin
                tick();
            end
        end
    endtask

    // strobes keep coming through drain, done sampled at negedge
    task automatic wait_done(input int limit);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            tick();
            coef_valid <= ($random(seed) & 1) != 0;
            drive_operands(0);
            @(negedge clk);
            seen = done;
        end
        if (!seen) begin
            timeout_cnt++;
            $display("timeout: done did not arrive within %0d cycles", limit);
        end
    endtask

    // ====================
    // test sequence
    // ====================

    initial begin
        seed        = 32'hebc3_8aaa;
        timeout_cnt = 0;
        clk         = 1'b0;
        reset_n     = 1'b0;
        zeroize     = 1'b0;
        start       = 1'b0;
        mode_sub    = 1'b0;
        count       = '0;
        coef_valid  = 1'b0;
        u           = '0;
        v           = '0;
        rnd_a2b     = '0;
        rnd_b2a     = '0;
        hold_reset();

        run_block(20, 1'b0, 0);
        wait_done(DONE_LIMIT);
        run_block(32, 1'b1, 0);
        wait_done(DONE_LIMIT);
        run_block(1, 1'b0, 0);
        wait_done(DONE_LIMIT);
        run_block(`MBFU_MAX_COUNT, 1'b1, 0);
        wait_done(DONE_LIMIT);
        // zeroize halfway, then a clean block
        run_block(40, 1'b0, 15);
        run_block(10, 1'b1, 0);
        wait_done(DONE_LIMIT);
        // reset from idle, then a clean block
        tick();
        hold_reset();
        run_block(12, 1'b0, 0);
        wait_done(DONE_LIMIT);
        for (int i = 0; i < 4; i++) begin
            tick();
        end

        assert_cnt = u_dut.u_props.fail_cnt;
        $display("errors: %0d assertion failures, %0d timeouts", assert_cnt, timeout_cnt);
        if (assert_cnt == 0 && timeout_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- masked_bfu.f
+incdir+hdl
hdl/masked_bfu_pkg.sv
hdl/masked_a2b_conv.sv
hdl/masked_b2a_bit.sv
hdl/masked_bfu_add_sub.sv
hdl/bfu_ctrl_fsm.sv
hdl/bfu_block_counter.sv
hdl/masked_bfu_top.sv
dv/masked_bfu_props.sv
dv/masked_bfu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the masked butterfly testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=masked_bfu_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$TOP" -f masked_bfu.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/V"$TOP" +verilator+error+limit+10000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
